// File: tb.f
hdl/s16_video_pkg.sv
hdl/s16_vtimer.sv
hdl/s16_scroll_regs.sv
hdl/s16_scroll_layer.sv
hdl/s16_layer_mixer.sv
hdl/s16_tile_video.sv
bench/tb_clock_gen.sv
bench/tb_rom_model.sv
bench/tb_tile_video.sv

// File: bench/tb_tile_video.sv
/* short frame of 64x24 dots, 48x18 visible, four clk per dot
   scroll and page values are random and writes land mid frame */
`timescale 1ns/10ps

module tb_tile_video;

    localparam int H_TOTAL    = 64;
    localparam int H_ACTIVE   = 48;
    localparam int V_TOTAL    = 24;
    localparam int V_ACTIVE   = 18;
    localparam int FRAME_CLKS = H_TOTAL * V_TOTAL * 4;

    logic clk, rst;
    logic pxl_cen, hblank, vblank;
    s16_video_pkg::pos_t       hdump, vdump;
    logic                      cpu_we;
    s16_video_pkg::cpu_addr_t  cpu_addr;
    logic [15:0]               cpu_din;
    s16_video_pkg::map_addr_t  fg_map_addr, bg_map_addr;
    s16_video_pkg::map_word_t  fg_map_data, bg_map_data;
    s16_video_pkg::tile_addr_t fg_scr_addr, bg_scr_addr;
    s16_video_pkg::tile_word_t fg_scr_data, bg_scr_data;
    s16_video_pkg::pixel_t     pxl_out;

    // reference state
    logic [1:0]                   since_cen;     // clks since last pxl_cen
    logic                         seen_cen;
    s16_video_pkg::pos_t          ref_h, ref_v;  // expected beam
    logic [15:0]                  sh_pages;      // what the cpu wrote
    s16_video_pkg::pos_t          sh_fg_h, sh_fg_v, sh_bg_h, sh_bg_v;
    s16_video_pkg::layer_scroll_t act_fg, act_bg;
    s16_video_pkg::map_addr_t     exp_fg_map, exp_bg_map;
    s16_video_pkg::map_word_t     fg_cur, fg_prev, bg_cur, bg_prev;  // words at capture
    s16_video_pkg::tile_word_t    fg_tile, bg_tile;
    s16_video_pkg::pixel_t        exp_out;

    tb_clock_gen #(.RST_CYCLES(8)) clk_gen (.clk, .rst);

    tb_rom_model fg_rom (
        .clk, .map_addr(fg_map_addr), .map_data(fg_map_data),
        .scr_addr(fg_scr_addr), .scr_data(fg_scr_data)
    );

    tb_rom_model bg_rom (
        .clk, .map_addr(bg_map_addr), .map_data(bg_map_data),
        .scr_addr(bg_scr_addr), .scr_data(bg_scr_data)
    );

    s16_tile_video #(
        .H_TOTAL(H_TOTAL), .H_ACTIVE(H_ACTIVE), .V_TOTAL(V_TOTAL), .V_ACTIVE(V_ACTIVE)
    ) dut0 (
        .clk, .rst, .pxl_cen, .hdump, .vdump, .hblank, .vblank,
        .cpu_we, .cpu_addr, .cpu_din,
        .fg_map_addr, .fg_map_data, .fg_scr_addr, .fg_scr_data,
        .bg_map_addr, .bg_map_data, .bg_scr_addr, .bg_scr_data,
        .pxl_out
    );

    // page then v row bits then h column bits with bit 5 flipped
    function automatic s16_video_pkg::map_addr_t expect_map_addr(
        s16_video_pkg::layer_scroll_t s, s16_video_pkg::pos_t h, s16_video_pkg::pos_t v);
        s16_video_pkg::pos_t hp, vp;
        hp = h + s.hscr;
        vp = v + s.vscr;
        return {s.page, vp[7:3], ~hp[8], hp[7:3]};
    endfunction

    // attribute from the map word and solid colour from one bit per plane
    function automatic s16_video_pkg::pixel_t layer_pixel(
        s16_video_pkg::map_word_t w, s16_video_pkg::tile_word_t t);
        s16_video_pkg::pixel_t p;
        p.prio    = w[12];
        p.palette = w[11:5];
        p.colour  = {t[16], t[8], t[0]};
        return p;
    endfunction

    function automatic s16_video_pkg::pixel_t mix_rule(
        s16_video_pkg::pixel_t fg, s16_video_pkg::pixel_t bg);
        logic fg_shows, bg_shows, bg_in_front;
        fg_shows    = |fg.colour;
        bg_shows    = |bg.colour;
        bg_in_front = bg_shows && bg.prio && !fg.prio;
        if (fg_shows && !bg_in_front)
            return fg;
        return bg_shows ? bg : '0;   // both clear gives black
    endfunction

    always @(posedge clk, posedge rst) begin
        if (rst) begin
            since_cen  <= '0;
            seen_cen   <= 1'b0;
            ref_h      <= '0;
            ref_v      <= '0;
            {sh_pages, sh_fg_h, sh_fg_v, sh_bg_h, sh_bg_v} <= '0;
            act_fg     <= '0;
            act_bg     <= '0;
            exp_fg_map <= '0;
            exp_bg_map <= '0;
            {fg_cur, fg_prev, bg_cur, bg_prev} <= '0;
            fg_tile    <= '0;
            bg_tile    <= '0;
            exp_out    <= '0;
        end else begin
            since_cen <= pxl_cen ? 2'd0 : since_cen + 2'd1;
            if (pxl_cen)
                seen_cen <= 1'b1;
            if (cpu_we) begin
                case (cpu_addr)
                    s16_video_pkg::REG_PAGES: sh_pages <= cpu_din;
                    s16_video_pkg::REG_FG_H:  sh_fg_h  <= cpu_din[8:0];
                    s16_video_pkg::REG_FG_V:  sh_fg_v  <= cpu_din[8:0];
                    s16_video_pkg::REG_BG_H:  sh_bg_h  <= cpu_din[8:0];
                    s16_video_pkg::REG_BG_V:  sh_bg_v  <= cpu_din[8:0];
                    default: ;
                endcase
            end
            if (pxl_cen) begin
                ref_h <= (ref_h == H_TOTAL - 1) ? '0 : ref_h + 9'd1;
                if (ref_h == H_TOTAL - 1)
                    ref_v <= (ref_v == V_TOTAL - 1) ? '0 : ref_v + 9'd1;
                if (ref_h == 0 && ref_v == V_ACTIVE) begin   // vblank start
                    act_fg.page <= sh_pages[14:12];
                    act_fg.hscr <= sh_fg_h;
                    act_fg.vscr <= sh_fg_v;
                    act_bg.page <= sh_pages[6:4];
                    act_bg.hscr <= sh_bg_h;
                    act_bg.vscr <= sh_bg_v;
                end
                if (ref_h[2:0] == 3'd0) begin
                    exp_fg_map <= expect_map_addr(act_fg, ref_h, ref_v);
                    exp_bg_map <= expect_map_addr(act_bg, ref_h, ref_v);
                end
                if (ref_h[2:0] == 3'd4) begin   // capture slot
                    fg_prev <= fg_cur;
                    fg_cur  <= fg_map_data;
                    fg_tile <= fg_scr_data;
                    bg_prev <= bg_cur;
                    bg_cur  <= bg_map_data;
                    bg_tile <= bg_scr_data;
                end
                exp_out <= (ref_h >= H_ACTIVE || ref_v >= V_ACTIVE) ? '0 :
                           mix_rule(layer_pixel(fg_prev, fg_tile), layer_pixel(bg_prev, bg_tile));
            end
        end
    end

    task automatic value_error(string name, logic [31:0] exp_v, logic [31:0] act_v);
        $display("Error at %0t: %s expected %0h got %0h", $time, name, exp_v, act_v);
        $display("tests failed");
        $fatal(1, "mismatch on %s", name);
    endtask

    task automatic run_failure(string what);
        $display("Timeout at %0t: %s", $time, what);
        $display("tests failed");
        $fatal(1, "%s", what);
    endtask

    a_cen: assert property (@(posedge clk) disable iff (rst)
        seen_cen |-> pxl_cen == (since_cen == 2'd3))
        else value_error("pxl_cen", $sampled(since_cen == 2'd3), $sampled(pxl_cen));
    a_hdump: assert property (@(posedge clk) disable iff (rst) hdump == ref_h)
        else value_error("hdump", $sampled(ref_h), $sampled(hdump));
    a_vdump: assert property (@(posedge clk) disable iff (rst) vdump == ref_v)
        else value_error("vdump", $sampled(ref_v), $sampled(vdump));
    a_hblank: assert property (@(posedge clk) disable iff (rst) hblank == (ref_h >= H_ACTIVE))
        else value_error("hblank", $sampled(ref_h >= H_ACTIVE), $sampled(hblank));
    a_vblank: assert property (@(posedge clk) disable iff (rst) vblank == (ref_v >= V_ACTIVE))
        else value_error("vblank", $sampled(ref_v >= V_ACTIVE), $sampled(vblank));
    a_fg_map: assert property (@(posedge clk) disable iff (rst) fg_map_addr == exp_fg_map)
        else value_error("fg_map_addr", $sampled(exp_fg_map), $sampled(fg_map_addr));
    a_bg_map: assert property (@(posedge clk) disable iff (rst) bg_map_addr == exp_bg_map)
        else value_error("bg_map_addr", $sampled(exp_bg_map), $sampled(bg_map_addr));
    // bank and code of the latest capture with the current row
    a_fg_scr: assert property (@(posedge clk) disable iff (rst)
        fg_scr_addr == {fg_cur[13], fg_cur[11:0], ref_v[2:0], 1'b0})
        else value_error("fg_scr_addr", $sampled({fg_cur[13], fg_cur[11:0], ref_v[2:0], 1'b0}),
                         $sampled(fg_scr_addr));
    a_bg_scr: assert property (@(posedge clk) disable iff (rst)
        bg_scr_addr == {bg_cur[13], bg_cur[11:0], ref_v[2:0], 1'b0})
        else value_error("bg_scr_addr", $sampled({bg_cur[13], bg_cur[11:0], ref_v[2:0], 1'b0}),
                         $sampled(bg_scr_addr));
    a_pxl_out: assert property (@(posedge clk) disable iff (rst) pxl_out == exp_out)
        else value_error("pxl_out", $sampled(exp_out), $sampled(pxl_out));

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (rst && n < 100) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (rst)
            run_failure("reset never released");
    endtask

    // beam outputs are read 1 ns after the edge
    task automatic wait_beam(s16_video_pkg::pos_t v, s16_video_pkg::pos_t h, int limit);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (!(vdump == v && hdump == h) && n < limit);
        if (!(vdump == v && hdump == h))
            run_failure($sformatf("beam never reached line %0d dot %0d", v, h));
    endtask

    task automatic cpu_write(s16_video_pkg::cpu_addr_t a, logic [15:0] d);
        @(posedge clk);
        #1;
        cpu_we   = 1'b1;
        cpu_addr = a;
        cpu_din  = d;
        @(posedge clk);
        #1;
        cpu_we   = 1'b0;
    endtask

    task automatic write_random_scroll();
        cpu_write(s16_video_pkg::REG_PAGES, 16'($urandom));
        cpu_write(s16_video_pkg::REG_FG_H, 16'($urandom));
        cpu_write(s16_video_pkg::REG_FG_V, 16'($urandom));
        cpu_write(s16_video_pkg::REG_BG_H, 16'($urandom));
        cpu_write(s16_video_pkg::REG_BG_V, 16'($urandom));
    endtask

    initial begin
        cpu_we   = 1'b0;
        cpu_addr = '0;
        cpu_din  = '0;
        void'($urandom(32'he0b20e32));
        wait_reset_release();
        for (int frame = 0; frame < 5; frame++) begin
            wait_beam(9'd5, 9'd20, FRAME_CLKS + 64);         // mid frame while old scroll holds
            write_random_scroll();
            wait_beam(V_ACTIVE, 9'd0, FRAME_CLKS + 64);      // copy lands here
            if (frame == 2)
                cpu_write(s16_video_pkg::REG_FG_H, 16'($urandom));  // write in vblank
        end
        // last copied scroll runs over one more visible frame
        wait_beam(s16_video_pkg::pos_t'(V_ACTIVE - 1), 9'd0, FRAME_CLKS + 64);
        $display("all tests passed");
        $finish;
    end

endmodule

// File: bench/tb_rom_model.sv
/* map and tile memory of one layer, data one clk after the address
   every tile plane byte is 00 or FF, so each fetched tile row has one colour */
`timescale 1ns/10ps

module tb_rom_model (
    input  logic                      clk,
    input  s16_video_pkg::map_addr_t  map_addr,
    output s16_video_pkg::map_word_t  map_data,
    input  s16_video_pkg::tile_addr_t scr_addr,
    output s16_video_pkg::tile_word_t scr_data
);

    // scrambled word so bank, code and attribute all move
    function automatic s16_video_pkg::map_word_t map_word(s16_video_pkg::map_addr_t a);
        logic [31:0] h;
        h = {18'd0, a} * 32'h9e3779b1;
        return h[31:16] ^ {a[7:0], a[13:6]};
    endfunction

    // plane select bits come from bank and code, row only reaches the spare byte
    function automatic s16_video_pkg::tile_word_t tile_word(s16_video_pkg::tile_addr_t a);
        logic p2, p1, p0;
        p2 = a[4] ^ a[11] ^ a[14];
        p1 = a[5] ^ a[16] ^ a[12];
        p0 = a[6] ^ a[9] ^ a[8];
        return {a[7:0] ^ a[16:9], {8{p2}}, {8{p1}}, {8{p0}}};   // top byte unused
    endfunction

    initial begin
        map_data <= '0;
        scr_data <= '0;
    end

    // one clk of read latency on both ports
    always @(posedge clk) begin
        map_data <= map_word(map_addr);
        scr_data <= tile_word(scr_addr);
    end

endmodule

// File: bench/tb_clock_gen.sv
/* 10 ns clock, rst high for the first RST_CYCLES rising edges */
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int RST_CYCLES = 8
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;   // 10 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst = 1'b0;           // released just after an edge
    end

endmodule

// File: hdl/s16_tile_video.sv
/* tile layer video: timer, scroll registers, fg and bg layers, mixer
   H_TOTAL at most 512 and a multiple of 8, memories answer within 4 pixel enables */
`timescale 1ns/10ps

module s16_tile_video #(
    parameter int H_TOTAL  = 384,
    parameter int H_ACTIVE = 320,
    parameter int V_TOTAL  = 262,
    parameter int V_ACTIVE = 224
) (
    input  logic                      clk,
    input  logic                      rst,
    output logic                      pxl_cen,
    output s16_video_pkg::pos_t       hdump,
    output s16_video_pkg::pos_t       vdump,
    output logic                      hblank,
    output logic                      vblank,
    // cpu side
    input  logic                      cpu_we,
    input  s16_video_pkg::cpu_addr_t  cpu_addr,
    input  logic [15:0]               cpu_din,
    // foreground memories
    output s16_video_pkg::map_addr_t  fg_map_addr,
    input  s16_video_pkg::map_word_t  fg_map_data,
    output s16_video_pkg::tile_addr_t fg_scr_addr,
    input  s16_video_pkg::tile_word_t fg_scr_data,
    // background memories
    output s16_video_pkg::map_addr_t  bg_map_addr,
    input  s16_video_pkg::map_word_t  bg_map_data,
    output s16_video_pkg::tile_addr_t bg_scr_addr,
    input  s16_video_pkg::tile_word_t bg_scr_data,
    output s16_video_pkg::pixel_t     pxl_out
);

    s16_video_pkg::layer_scroll_t fg_scroll, bg_scroll;
    s16_video_pkg::pixel_t        fg_pxl, bg_pxl;

    s16_vtimer #(
        .H_TOTAL  (H_TOTAL),
        .H_ACTIVE (H_ACTIVE),
        .V_TOTAL  (V_TOTAL),
        .V_ACTIVE (V_ACTIVE)
    ) timer (
        .clk, .rst, .pxl_cen, .hdump, .vdump, .hblank, .vblank
    );

    s16_scroll_regs #(.V_ACTIVE(V_ACTIVE)) regs (
        .clk, .rst, .cpu_we, .cpu_addr, .cpu_din,
        .pxl_cen, .hdump, .vdump, .fg_scroll, .bg_scroll
    );

    s16_scroll_layer fg_layer (
        .clk, .rst, .pxl_cen, .hdump, .vdump,
        .scroll   (fg_scroll),
        .map_addr (fg_map_addr),
        .map_data (fg_map_data),
        .scr_addr (fg_scr_addr),
        .scr_data (fg_scr_data),
        .pxl      (fg_pxl)
    );

    s16_scroll_layer bg_layer (
        .clk, .rst, .pxl_cen, .hdump, .vdump,
        .scroll   (bg_scroll),
        .map_addr (bg_map_addr),
        .map_data (bg_map_data),
        .scr_addr (bg_scr_addr),
        .scr_data (bg_scr_data),
        .pxl      (bg_pxl)
    );

    s16_layer_mixer mixer (
        .clk, .rst, .pxl_cen, .hblank, .vblank,
        .fg_pxl, .bg_pxl, .pxl_out
    );

endmodule

// File: hdl/s16_layer_mixer.sv
/* picks fg or bg per pixel where colour 0 is transparent
   one pixel enable of latency and black during blanking */
`timescale 1ns/10ps

module s16_layer_mixer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pxl_cen,
    input  logic                  hblank,
    input  logic                  vblank,
    input  s16_video_pkg::pixel_t fg_pxl,
    input  s16_video_pkg::pixel_t bg_pxl,
    output s16_video_pkg::pixel_t pxl_out
);

    logic                  fg_op, bg_op;  // opaque flags
    logic                  bg_over;       // bg priority beats fg
    s16_video_pkg::pixel_t mix;

    assign fg_op   = fg_pxl.colour != 3'd0;
    assign bg_op   = bg_pxl.colour != 3'd0;
    assign bg_over = bg_op && bg_pxl.prio && !fg_pxl.prio;

    always_comb begin
        if (hblank || vblank)
            mix = '0;
        else if (fg_op && !bg_over)
            mix = fg_pxl;
        else if (bg_op)
            mix = bg_pxl;
        else
            mix = '0;   // both clear
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            pxl_out <= '0;
        end else if (pxl_cen) begin
            pxl_out <= mix;
        end
    end

endmodule

// File: hdl/s16_scroll_layer.sv
/* one scroll layer, 8x8 tiles, 3 planes per tile row
   map and tile memory must answer within half a tile (4 pixel enables) */
`timescale 1ns/10ps

module s16_scroll_layer (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         pxl_cen,
    input  s16_video_pkg::pos_t          hdump,
    input  s16_video_pkg::pos_t          vdump,
    input  s16_video_pkg::layer_scroll_t scroll,
    output s16_video_pkg::map_addr_t     map_addr,
    input  s16_video_pkg::map_word_t     map_data,
    output s16_video_pkg::tile_addr_t    scr_addr,
    input  s16_video_pkg::tile_word_t    scr_data,
    output s16_video_pkg::pixel_t        pxl
);

    s16_video_pkg::pos_t hpos, vpos;   // beam + scroll
    logic [10:0]         scan_addr;    // 32 rows x 64 columns
    logic [12:0]         code;         // bank + tile code
    logic [7:0]          attr0;        // attribute of the tile being fetched
    logic [7:0]          attr;         // attribute of the tile on screen
    logic [23:0]         planes;       // three 8-bit planes
    logic                map_slot;     // hdump at tile start
    logic                cap_slot;     // half way through the tile

    assign hpos      = hdump + scroll.hscr;
    assign vpos      = vdump + scroll.vscr;
    assign scan_addr = {vpos[7:3], hpos[8:3]};

    assign map_slot = pxl_cen && hdump[2:0] == 3'd0;
    assign cap_slot = pxl_cen && hdump[2:0] == 3'd4;

    // tilemap fetch, column bit 5 is swapped in the map layout
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            map_addr <= '0;
        end else if (map_slot) begin
            map_addr <= {scroll.page, scan_addr ^ 11'h020};
        end
    end

    // graphics address follows the captured code and current row
    assign scr_addr = {code, vdump[2:0], 1'b0};

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            code   <= '0;
            attr0  <= '0;
            attr   <= '0;
            planes <= '0;
        end else if (cap_slot) begin
            planes <= scr_data[23:0];          // graphics of the previous code
            attr   <= attr0;                   // attribute lines up with it
            attr0  <= map_data[12:5];
            code   <= {map_data[13], map_data[11:0]};
        end else if (pxl_cen) begin
            // msb first in each plane
            planes[23:16] <= {planes[22:16], 1'b0};
            planes[15:8]  <= {planes[14:8], 1'b0};
            planes[7:0]   <= {planes[6:0], 1'b0};
        end
    end

    always_comb begin
        pxl.prio    = attr[7];
        pxl.palette = attr[6:0];
        pxl.colour  = {planes[23], planes[15], planes[7]};
    end

    // map fetch must only move at the tile start slot
    a_map_addr_slot: assert property (
        @(posedge clk) disable iff (rst)
        !$stable(map_addr) |-> $past(map_slot)
    );

endmodule

// File: hdl/s16_scroll_regs.sv
/* cpu writes go to shadow registers, the layers only see them after vblank start
   indices above REG_BG_V are not decoded */
`timescale 1ns/10ps

module s16_scroll_regs #(
    parameter int V_ACTIVE = 224
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         cpu_we,     // one clk strobe
    input  s16_video_pkg::cpu_addr_t     cpu_addr,
    input  logic [15:0]                  cpu_din,
    input  logic                         pxl_cen,
    input  s16_video_pkg::pos_t          hdump,
    input  s16_video_pkg::pos_t          vdump,
    output s16_video_pkg::layer_scroll_t fg_scroll,
    output s16_video_pkg::layer_scroll_t bg_scroll
);

    logic [15:0]         pages;               // shadow copy
    s16_video_pkg::pos_t fg_h, fg_v, bg_h, bg_v;
    logic                frame_start;

    // first dot of the first blank line
    assign frame_start = pxl_cen && hdump == '0 &&
                         vdump == s16_video_pkg::pos_t'(V_ACTIVE);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            pages <= '0;
            fg_h  <= '0;
            fg_v  <= '0;
            bg_h  <= '0;
            bg_v  <= '0;
        end else if (cpu_we) begin
            case (cpu_addr)
                s16_video_pkg::REG_PAGES: pages <= cpu_din;
                s16_video_pkg::REG_FG_H:  fg_h  <= cpu_din[8:0];  // scroll is 9 bits
                s16_video_pkg::REG_FG_V:  fg_v  <= cpu_din[8:0];
                s16_video_pkg::REG_BG_H:  bg_h  <= cpu_din[8:0];
                s16_video_pkg::REG_BG_V:  bg_v  <= cpu_din[8:0];
                default: ;
            endcase
        end
    end

    // active copy, constant over the visible frame
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            fg_scroll <= '0;
            bg_scroll <= '0;
        end else if (frame_start) begin
            fg_scroll.page <= pages[14:12];
            fg_scroll.hscr <= fg_h;
            fg_scroll.vscr <= fg_v;
            bg_scroll.page <= pages[6:4];
            bg_scroll.hscr <= bg_h;
            bg_scroll.vscr <= bg_v;
        end
    end

    a_cpu_index: assert property (
        @(posedge clk) disable iff (rst) cpu_we |-> cpu_addr <= s16_video_pkg::REG_BG_V
    );

endmodule

// File: hdl/s16_vtimer.sv
/* free running beam timer, pixel enable is clk/4
   H_TOTAL should be a multiple of 8 so tiles line up with hdump[2:0] */
`timescale 1ns/10ps

module s16_vtimer #(
    parameter int H_TOTAL  = 384,
    parameter int H_ACTIVE = 320,
    parameter int V_TOTAL  = 262,
    parameter int V_ACTIVE = 224
) (
    input  logic                clk,
    input  logic                rst,
    output logic                pxl_cen,
    output s16_video_pkg::pos_t hdump,
    output s16_video_pkg::pos_t vdump,
    output logic                hblank,
    output logic                vblank
);

    logic [1:0]                 div;      // clock divider
    s16_video_pkg::pos_t        h_nxt, v_nxt;
    logic                       h_wrap;   // last dot of the line
    s16_video_pkg::vt_state_e   state, state_nxt;

    assign h_wrap = hdump == s16_video_pkg::pos_t'(H_TOTAL - 1);
    assign h_nxt  = h_wrap ? '0 : hdump + 9'd1;

    always_comb begin
        v_nxt = vdump;
        if (h_wrap) begin
            v_nxt = (vdump == s16_video_pkg::pos_t'(V_TOTAL - 1)) ? '0 : vdump + 9'd1;
        end
        // state follows the counters on the same edge
        if (v_nxt >= s16_video_pkg::pos_t'(V_ACTIVE))
            state_nxt = s16_video_pkg::VT_VBLANK;
        else if (h_nxt >= s16_video_pkg::pos_t'(H_ACTIVE))
            state_nxt = s16_video_pkg::VT_HBLANK;
        else
            state_nxt = s16_video_pkg::VT_ACTIVE;
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            div     <= 2'd0;
            pxl_cen <= 1'b0;
            hdump   <= '0;
            vdump   <= '0;
            state   <= s16_video_pkg::VT_ACTIVE;
        end else begin
            div     <= div + 2'd1;
            pxl_cen <= div == 2'd3;   // one clk in four
            if (pxl_cen) begin
                hdump <= h_nxt;
                vdump <= v_nxt;
                state <= state_nxt;
            end
        end
    end

    // in vblank the state hides hblank, so look at hdump again
    assign vblank = state == s16_video_pkg::VT_VBLANK;
    assign hblank = (state == s16_video_pkg::VT_HBLANK) ||
                    (vblank && hdump >= s16_video_pkg::pos_t'(H_ACTIVE));

    a_hdump_range: assert property (
        @(posedge clk) disable iff (rst) hdump < s16_video_pkg::pos_t'(H_TOTAL)
    );

endmodule

// File: hdl/s16_video_pkg.sv
/* shared widths and records for the tile video path
   beam and scroll coordinates are 9 bits, so totals must stay at or below 512 */

package s16_video_pkg;

    typedef logic [8:0]  pos_t;        // beam or scroll coordinate
    typedef logic [13:0] map_addr_t;   // 3-bit page + 11-bit scan address
    typedef logic [16:0] tile_addr_t;  // bank, code, tile row, 0
    typedef logic [15:0] map_word_t;   // [13] bank, [12:5] attr, [11:0] code
    typedef logic [31:0] tile_word_t;  // low 24 bits hold three 8-bit planes
    typedef logic [2:0]  cpu_addr_t;   // register index

    // one pixel of a layer, also the mixer output
    typedef struct packed {
        logic       prio;     // layer priority bit
        logic [6:0] palette;  // palette bank
        logic [2:0] colour;   // 0 is transparent
    } pixel_t;

    // scroll set seen by one layer
    typedef struct packed {
        pos_t       hscr;
        pos_t       vscr;
        logic [2:0] page;
    } layer_scroll_t;

    // cpu register map
    localparam cpu_addr_t REG_PAGES = 3'd0;  // fg page in [14:12], bg page in [6:4]
    localparam cpu_addr_t REG_FG_H  = 3'd1;
    localparam cpu_addr_t REG_FG_V  = 3'd2;
    localparam cpu_addr_t REG_BG_H  = 3'd3;
    localparam cpu_addr_t REG_BG_V  = 3'd4;

    // video timer states
    typedef enum logic [1:0] {
        VT_ACTIVE = 2'd0,
        VT_HBLANK = 2'd1,
        VT_VBLANK = 2'd2   // wins over hblank
    } vt_state_e;

endpackage
